// ==== tb.f ====
fireGamePkg.sv
fireScreenPkg.sv
beatTimer.sv
gameControl.sv
jumperSlot.sv
pixelSelect.sv
fireGame.sv
fireGameTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module fireGameTb \
	-f tb.f -o simFireGame > build.log 2>&1 &&
{ ./obj_dir/simFireGame > sim.log 2>&1 || true; } &&
grep -qx "all tests passed" sim.log &&
echo "PASS" || { echo "FAIL"; exit 1; }

// ==== fireGameTb.sv ====
`default_nettype none

module fireGameTb
	import fireGamePkg::*, fireScreenPkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TbTicksPerFrame = 4; // 16 playing cycles per beat
	localparam int TimeoutCycles = 20_000; // Well over four games of 40 beats
	localparam int KeyLeft = 0;
	localparam int KeyRight = 1;
	localparam int KeyEsc = 2;
	localparam int KeyEnter = 3;

	logic Clock;
	logic rstN, Enable, Left, Right, Esc, Enter;
	randT Rand;
	xCoordT VGAx;
	yCoordT VGAy;
	pixSourceT pixSource;
	pixIndexT pixIndex;
	scoreT Score;
	livesT Lives;
	logic gamePlaying;
	logic Quit;

	int seed;
	int cycleCount = 0;
	logic [31:0] probeWord;

	tickT modelTick;
	int modelFrame;
	playStateT modelState;
	logic modelPending, modelLeft;
	posT modelPos;
	jumperVecT modelJumpers;
	randT modelRand;
	scoreT modelScore;
	livesT modelLives;
	logic modelQuit;
	pixSourceT modelSource;
	pixIndexT modelIndex;
	logic modelFramePulse, modelBeatPulse;

	fireGame #(
		.TicksPerFrame(TbTicksPerFrame)
	) u_fireGame (
		.Clock(Clock),
		.rstN(rstN),
		.Enable(Enable),
		.Left(Left),
		.Right(Right),
		.Esc(Esc),
		.Enter(Enter),
		.Rand(Rand),
		.VGAx(VGAx),
		.VGAy(VGAy),
		.pixSource(pixSource),
		.pixIndex(pixIndex),
		.Score(Score),
		.Lives(Lives),
		.Playing(gamePlaying),
		.Quit(Quit)
	);

	initial begin
		Clock = 1'b0;
		forever #5 Clock = ~Clock;
	end

	// Probe offsets drawn here too, so the random sequence stays in one process
	always @(posedge Clock) begin
		Rand <= randT'($random(seed));
		probeWord <= $random(seed);
	end

	always @(posedge Clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles) begin
			$display("simulation timed out after %0d cycles", cycleCount);
			abortRun();
		end
	end

	function automatic int deathSlot(input int lane);
		case (lane)
			0: return DeathSlotLeft;
			1: return DeathSlotCentre;
			default: return DeathSlotRight;
		endcase
	endfunction

	// Source in the top two bits, sprite index below
	function automatic logic [15:0] expectPixel(input int x, input int y, input int pos,
		input jumperVecT occ, input randT r);
		int trampLeft;
		int dx;
		int dy;
		int o;
		int f;
		int base;
		logic [15:0] result;
		result = {Blank, 14'd0};
		trampLeft = int'(TrampX[pos]);
		if (y >= 180 && y < 216 && x >= trampLeft && x < trampLeft + 79) begin
			result = {Trampoline, 14'(79 * (y - 180) + x - trampLeft)};
		end
		for (int k = NumSlots - 1; k >= 0; k--) begin
			dx = x - int'(SlotX[k]);
			dy = y - int'(SlotY[k]);
			if (occ[k] && dx >= 0 && dx < 25 && dy >= 0 && dy < 25) begin
				o = (k >= 10) ? int'(r[12:10]) : int'(r[4:2]);
				f = (k >= 10) ? int'(r[9:8]) : int'(r[1:0]);
				case (o)
					0: base = 25 * dy + dx;
					1: base = 25 * dx + dy;
					2: base = 600 + dy - 25 * dx;
					3: base = 600 + dx - 25 * dy;
					4: base = 624 - 25 * dy - dx;
					5: base = 624 - 25 * dx - dy;
					6: base = 24 - dy + 25 * dx;
					default: base = 24 - dx + 25 * dy;
				endcase
				if (k == 0) begin
					result = {Spawn, 14'(25 * dy + dx)};
				end else begin
					result = {Falling, 14'(base + 625 * f)};
				end
			end
		end
		return result;
	endfunction

	assign modelFramePulse = (modelState == fireGamePkg::Playing)
		&& (modelTick == tickT'(TbTicksPerFrame - 1));
	assign modelBeatPulse = modelFramePulse && (modelFrame == FramesPerBeat - 1);

	always @(posedge Clock) begin : referenceModel
		playStateT st;
		logic pend;
		logic goLeft;
		int pos;
		jumperVecT chain;
		livesT used;
		logic quit;
		logic [15:0] pix;
		pix = expectPixel(int'(VGAx), int'(VGAy), int'(modelPos), modelJumpers, modelRand);
		if (!rstN || !Enable) begin
			modelTick <= '0;
			modelFrame <= 0;
			modelState <= Paused;
			modelPending <= 1'b0;
			modelLeft <= 1'b0;
			modelPos <= 2'd0;
			modelJumpers <= jumperVecT'(1);
			modelRand <= '0;
			modelScore <= '0;
			modelLives <= '0;
			modelQuit <= 1'b0;
			modelSource <= Blank;
			modelIndex <= '0;
		end else begin
			st = modelState;
			pend = modelPending;
			goLeft = modelLeft;
			pos = int'(modelPos);
			chain = modelJumpers;
			used = modelLives;
			quit = modelQuit;
			if (modelFramePulse) begin
				modelTick <= '0;
				modelFrame <= modelBeatPulse ? 0 : modelFrame + 1;
			end else if (modelState == fireGamePkg::Playing) begin
				modelTick <= modelTick + 1'b1;
			end
			if (modelFramePulse && pend) begin // Move clamped at both ends
				if (goLeft) begin
					pos = (pos > 0) ? pos - 1 : 0;
				end else begin
					pos = (pos < 2) ? pos + 1 : 2;
				end
				pend = 1'b0;
			end
			if (modelBeatPulse) begin
				modelRand <= Rand;
				modelScore <= modelScore + scoreT'(modelJumpers[NumSlots-1]);
				for (int lane = 0; lane < 3; lane++) begin
					if (chain[deathSlot(lane)] && pos != lane) begin
						chain[deathSlot(lane)] = 1'b0;
						if (used != 2'd3) used = used + 2'd1;
						st = Paused;
					end
				end
				chain = chain << 1;
				chain[0] = chain[RespawnSlot] || (chain == '0);
			end
			if (st == fireGamePkg::Playing && Left != Right) begin
				pend = 1'b1;
				goLeft = Left;
			end
			if (Esc) begin
				if (st == Paused) quit = 1'b1;
				st = Paused;
			end else if (Enter) begin
				if (used == 2'd3) quit = 1'b1;
				else st = fireGamePkg::Playing;
			end
			modelState <= st;
			modelPending <= pend;
			modelLeft <= goLeft;
			modelPos <= posT'(pos);
			modelJumpers <= chain;
			modelLives <= used;
			modelQuit <= quit;
			modelSource <= pixSourceT'(pix[15:14]);
			modelIndex <= pix[13:0];
		end
	end

	assert property (@(posedge Clock) disable iff (!rstN) pixSource == modelSource)
		else reportMismatch("pixSource", 32'($sampled(pixSource)), 32'($sampled(modelSource)));
	assert property (@(posedge Clock) disable iff (!rstN) pixIndex == modelIndex)
		else reportMismatch("pixIndex", 32'($sampled(pixIndex)), 32'($sampled(modelIndex)));
	assert property (@(posedge Clock) disable iff (!rstN) Score == modelScore)
		else reportMismatch("Score", 32'($sampled(Score)), 32'($sampled(modelScore)));
	assert property (@(posedge Clock) disable iff (!rstN) Lives == modelLives)
		else reportMismatch("Lives", 32'($sampled(Lives)), 32'($sampled(modelLives)));
	assert property (@(posedge Clock) disable iff (!rstN)
		gamePlaying == (modelState == fireGamePkg::Playing))
		else reportMismatch("Playing", 32'($sampled(gamePlaying)), 32'($sampled(modelState)));
	assert property (@(posedge Clock) disable iff (!rstN) Quit == modelQuit)
		else reportMismatch("Quit", 32'($sampled(Quit)), 32'($sampled(modelQuit)));
	assert property (@(posedge Clock) disable iff (!rstN) u_fireGame.position == modelPos)
		else reportMismatch("position", 32'($sampled(u_fireGame.position)),
			32'($sampled(modelPos)));
	assert property (@(posedge Clock) disable iff (!rstN) u_fireGame.jumpers == modelJumpers)
		else reportMismatch("jumpers", 32'($sampled(u_fireGame.jumpers)),
			32'($sampled(modelJumpers)));
	assert property (@(posedge Clock) disable iff (!rstN) u_fireGame.randHold == modelRand)
		else reportMismatch("randHold", 32'($sampled(u_fireGame.randHold)),
			32'($sampled(modelRand)));
	assert property (@(posedge Clock) disable iff (!rstN)
		u_fireGame.framePulse == modelFramePulse)
		else reportMismatch("framePulse", 32'($sampled(u_fireGame.framePulse)),
			32'($sampled(modelFramePulse)));
	assert property (@(posedge Clock) disable iff (!rstN)
		u_fireGame.beatPulse == modelBeatPulse)
		else reportMismatch("beatPulse", 32'($sampled(u_fireGame.beatPulse)),
			32'($sampled(modelBeatPulse)));

	task automatic reportMismatch(input string name, input logic [31:0] dutValue,
		input logic [31:0] expected);
		$display("CHECK FAILED %s dut=%h expected=%h", name, dutValue, expected);
		abortRun();
	endtask

	task automatic abortRun();
		$display("tests failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic applyReset();
		@(posedge Clock);
		rstN <= 1'b0;
		repeat (5) @(posedge Clock);
		rstN <= 1'b1;
	endtask

	task automatic pressKey(input int key);
		@(posedge Clock);
		case (key)
			KeyLeft: Left <= 1'b1;
			KeyRight: Right <= 1'b1;
			KeyEsc: Esc <= 1'b1;
			default: Enter <= 1'b1;
		endcase
		@(posedge Clock);
		Left <= 1'b0;
		Right <= 1'b0;
		Esc <= 1'b0;
		Enter <= 1'b0;
	endtask

	// Returns on the edge where a frame takes effect
	task automatic waitFrame();
		do @(posedge Clock); while (!modelFramePulse);
	endtask

	task automatic startPlay();
		pressKey(KeyEnter);
		while (!gamePlaying) @(posedge Clock);
	endtask

	// One key press per frame towards the busy death slot, plus a pixel probe
	task automatic steerAndProbe();
		int target;
		int slot;
		int dx;
		int dy;
		waitFrame();
		@(posedge Clock);
		target = int'(modelPos);
		if (modelJumpers[DeathSlotLeft]) target = 0;
		else if (modelJumpers[DeathSlotCentre]) target = 1;
		else if (modelJumpers[DeathSlotRight]) target = 2;
		if (target > int'(modelPos)) Right <= 1'b1;
		else if (target < int'(modelPos)) Left <= 1'b1;
		slot = 0;
		for (int k = 1; k < NumSlots; k++) begin
			if (modelJumpers[k]) slot = k;
		end
		dx = int'(probeWord[15:0]) % 25;
		dy = int'(probeWord[31:16]) % 25;
		if (slot != 0) begin
			VGAx <= xCoordT'(int'(SlotX[slot]) + dx);
			VGAy <= yCoordT'(int'(SlotY[slot]) + dy);
		end else begin
			VGAx <= xCoordT'(int'(TrampX[modelPos]) + dx);
			VGAy <= yCoordT'(int'(TrampY0) + dy);
		end
		@(posedge Clock);
		Left <= 1'b0;
		Right <= 1'b0;
	endtask

	initial begin
		seed = 32'h3b3c81cc;
		rstN = 1'b0;
		Enable = 1'b1;
		Left = 1'b0;
		Right = 1'b0;
		Esc = 1'b0;
		Enter = 1'b0;
		Rand = '0;
		VGAx = '0;
		VGAy = '0;
		repeat (5) @(posedge Clock);
		rstN <= 1'b1;

		@(posedge Clock);
		VGAx <= 9'd20; // Inside the spawn slot
		VGAy <= 8'd40;
		repeat (100) @(posedge Clock); // Paused, chain must hold

		startPlay();
		repeat (3) begin
			pressKey(KeyRight);
			waitFrame();
		end
		@(posedge Clock);
		VGAx <= 9'd180;
		VGAy <= 8'd190;
		repeat (2) @(posedge Clock);

		while (gamePlaying) @(posedge Clock); // Trampoline away from slot 4

		startPlay();
		while (Score == '0) steerAndProbe();

		pressKey(KeyEsc);
		pressKey(KeyEsc);
		while (!Quit) @(posedge Clock);

		@(posedge Clock);
		Enable <= 1'b0; // Clears the game like a reset
		repeat (3) @(posedge Clock);
		Enable <= 1'b1;

		applyReset();
		startPlay();
		pressKey(KeyRight);
		waitFrame();
		while (gamePlaying) @(posedge Clock);
		repeat (2) begin
			startPlay();
			while (gamePlaying) @(posedge Clock);
		end
		pressKey(KeyEnter); // Out of lives
		while (!Quit) @(posedge Clock);
		repeat (20) @(posedge Clock);

		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== fireGame.sv ====
`default_nettype none

module fireGame
	import fireGamePkg::*, fireScreenPkg::*;
#(
	parameter int TicksPerFrame = DefaultTicksPerFrame
) (
	input wire Clock,
	input wire rstN,
	input wire Enable,
	input wire Left,
	input wire Right,
	input wire Esc,
	input wire Enter,
	input wire randT Rand,
	input wire xCoordT VGAx,
	input wire yCoordT VGAy,
	output pixSourceT pixSource,
	output pixIndexT pixIndex,
	output scoreT Score,
	output livesT Lives,
	output logic Playing,
	output logic Quit
);

	logic framePulse;
	logic beatPulse;
	posT position;
	jumperVecT jumpers;
	randT randHold;
	jumperVecT slotHit;
	pixIndexT slotIndex [NumSlots];

	beatTimer #(
		.TicksPerFrame(TicksPerFrame)
	) u_beatTimer (
		.Clock(Clock),
		.rstN(rstN),
		.Enable(Enable),
		.Playing(Playing),
		.framePulse(framePulse),
		.beatPulse(beatPulse)
	);

	gameControl u_gameControl (
		.Clock(Clock),
		.rstN(rstN),
		.Enable(Enable),
		.Left(Left),
		.Right(Right),
		.Esc(Esc),
		.Enter(Enter),
		.Rand(Rand),
		.framePulse(framePulse),
		.beatPulse(beatPulse),
		.position(position),
		.jumpers(jumpers),
		.randHold(randHold),
		.Score(Score),
		.Lives(Lives),
		.Playing(Playing),
		.Quit(Quit)
	);

	for (genvar k = 0; k < NumSlots; k++) begin : gSlot
		jumperSlot #(
			.SlotIndex(k)
		) u_jumperSlot (
			.VGAx(VGAx),
			.VGAy(VGAy),
			.occupied(jumpers[k]),
			.randHold(randHold),
			.hit(slotHit[k]),
			.index(slotIndex[k])
		);
	end

	pixelSelect u_pixelSelect (
		.Clock(Clock),
		.rstN(rstN),
		.Enable(Enable),
		.VGAx(VGAx),
		.VGAy(VGAy),
		.position(position),
		.slotHit(slotHit),
		.slotIndex(slotIndex),
		.pixSource(pixSource),
		.pixIndex(pixIndex)
	);

endmodule

`default_nettype wire

// ==== pixelSelect.sv ====
`default_nettype none

module pixelSelect
	import fireGamePkg::*, fireScreenPkg::*;
(
	input wire Clock,
	input wire rstN,
	input wire Enable,
	input wire xCoordT VGAx,
	input wire yCoordT VGAy,
	input wire posT position,
	input wire jumperVecT slotHit,
	input wire pixIndexT slotIndex [NumSlots],
	output pixSourceT pixSource,
	output pixIndexT pixIndex
);

	xCoordT trampLeft;
	logic trampHit;
	pixIndexT trampIndex;
	pixSourceT nextSource;
	pixIndexT nextIndex;

	assign trampLeft = TrampX[position];
	assign trampHit = (VGAy >= TrampY0) && (VGAy < TrampY0 + TrampHeight)
		&& (VGAx >= trampLeft) && (VGAx < trampLeft + TrampWidth);
	assign trampIndex = pixIndexT'(TrampWidth) * pixIndexT'(VGAy - TrampY0)
		+ pixIndexT'(VGAx - trampLeft);

	always_comb begin
		nextSource = Blank;
		nextIndex = '0;
		if (trampHit) begin
			nextSource = Trampoline;
			nextIndex = trampIndex;
		end
		// Jumpers drawn over the trampoline, lowest slot on top
		for (int k = NumSlots - 1; k >= 0; k--) begin
			if (slotHit[k]) begin
				nextSource = (k == 0) ? Spawn : Falling;
				nextIndex = slotIndex[k];
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (!rstN || !Enable) begin
			pixSource <= Blank;
			pixIndex <= '0;
		end else begin
			pixSource <= nextSource;
			pixIndex <= nextIndex;
		end
	end

	// Four frames of the falling sprite
	assert property (@(posedge Clock) disable iff (!rstN || !Enable)
		pixSource == Falling |-> pixIndex < pixIndexT'(4 * FrameStride))
		else $error("pixelSelect: falling index past sprite ROM");

endmodule

`default_nettype wire

// ==== jumperSlot.sv ====
`default_nettype none

module jumperSlot
	import fireGamePkg::*, fireScreenPkg::*;
#(
	parameter int SlotIndex = 0
) (
	input wire xCoordT VGAx,
	input wire yCoordT VGAy,
	input wire occupied,
	input wire randT randHold,
	output logic hit,
	output pixIndexT index
);

	localparam xCoordT CornerX = SlotX[SlotIndex];
	localparam yCoordT CornerY = SlotY[SlotIndex];
	localparam bit UpperField = (SlotIndex >= 10); // Second half of the path
	localparam pixIndexT Stride = pixIndexT'(JumperSize);
	localparam pixIndexT LastCol = pixIndexT'(JumperSize - 1);
	localparam pixIndexT LastRow = pixIndexT'(JumperSize * (JumperSize - 1));
	localparam pixIndexT LastPix = pixIndexT'(JumperSize * JumperSize - 1);

	logic inBox;
	pixIndexT dx, dy;
	logic [2:0] orient;
	logic [1:0] frame;
	pixIndexT base;

	assign inBox = (VGAx >= CornerX) && (VGAx < CornerX + JumperSize)
		&& (VGAy >= CornerY) && (VGAy < CornerY + JumperSize);
	assign hit = occupied && inBox;

	assign dx = pixIndexT'(VGAx - CornerX);
	assign dy = pixIndexT'(VGAy - CornerY);

	assign orient = UpperField ? randHold[12:10] : randHold[4:2];
	assign frame = UpperField ? randHold[9:8] : randHold[1:0];

	// Rotations and mirrors of the 25x25 sprite
	always_comb begin
		case (orient)
			3'd0: base = Stride * dy + dx;
			3'd1: base = Stride * dx + dy;
			3'd2: base = LastRow + dy - Stride * dx;
			3'd3: base = LastRow + dx - Stride * dy;
			3'd4: base = LastPix - Stride * dy - dx;
			3'd5: base = LastPix - Stride * dx - dy;
			3'd6: base = LastCol - dy + Stride * dx;
			default: base = LastCol - dx + Stride * dy;
		endcase
	end

	// Spawn sprite is drawn upright, single frame
	assign index = (SlotIndex == 0) ? Stride * dy + dx
		: base + pixIndexT'(FrameStride * frame);

endmodule

`default_nettype wire

// ==== gameControl.sv ====
`default_nettype none

module gameControl
	import fireGamePkg::*;
(
	input wire Clock,
	input wire rstN,
	input wire Enable,
	input wire Left,
	input wire Right,
	input wire Esc,
	input wire Enter,
	input wire randT Rand,
	input wire framePulse,
	input wire beatPulse,
	output posT position,
	output jumperVecT jumpers,
	output randT randHold,
	output scoreT Score,
	output livesT Lives,
	output logic Playing,
	output logic Quit
);

	playStateT state, nextState;
	logic dirPending, nextDirPending;
	logic dirLeft, nextDirLeft;
	posT nextPos;
	jumperVecT nextJumpers;
	randT nextRand;
	scoreT nextScore;
	livesT nextLives;
	logic nextQuit;

	assign Playing = (state == fireGamePkg::Playing);

	// Steps run in game order, each one sees the result of the one before
	always_comb begin
		nextState = state;
		nextDirPending = dirPending;
		nextDirLeft = dirLeft;
		nextPos = position;
		nextJumpers = jumpers;
		nextRand = randHold;
		nextScore = Score;
		nextLives = Lives;
		nextQuit = Quit;

		if (framePulse && dirPending) begin
			if (dirLeft && position != 2'd0) begin
				nextPos = position - 2'd1;
			end else if (!dirLeft && position != 2'd2) begin
				nextPos = position + 2'd1;
			end
			nextDirPending = 1'b0;
		end

		if (beatPulse) begin
			nextRand = Rand;
			nextScore = Score + scoreT'(jumpers[NumSlots-1]); // Into the ambulance
			// Deaths judged against the trampoline as moved this frame
			if (nextJumpers[DeathSlotLeft] && nextPos != 2'd0) begin
				nextJumpers[DeathSlotLeft] = 1'b0;
				nextLives = (&nextLives) ? nextLives : nextLives + 2'd1;
				nextState = Paused;
			end
			if (nextJumpers[DeathSlotCentre] && nextPos != 2'd1) begin
				nextJumpers[DeathSlotCentre] = 1'b0;
				nextLives = (&nextLives) ? nextLives : nextLives + 2'd1;
				nextState = Paused;
			end
			if (nextJumpers[DeathSlotRight] && nextPos != 2'd2) begin
				nextJumpers[DeathSlotRight] = 1'b0;
				nextLives = (&nextLives) ? nextLives : nextLives + 2'd1;
				nextState = Paused;
			end
			nextJumpers = {nextJumpers[NumSlots-2:0], 1'b0};
			nextJumpers[0] = nextJumpers[RespawnSlot] || (nextJumpers == '0);
		end

		if (nextState == fireGamePkg::Playing) begin
			if (Left && !Right) begin
				nextDirPending = 1'b1;
				nextDirLeft = 1'b1;
			end else if (Right && !Left) begin
				nextDirPending = 1'b1;
				nextDirLeft = 1'b0;
			end
		end

		if (Esc) begin
			if (nextState == Paused) begin
				nextQuit = 1'b1; // Second Esc leaves the game
			end
			nextState = Paused;
		end else if (Enter) begin
			if (&nextLives) begin
				nextQuit = 1'b1;
			end else begin
				nextState = fireGamePkg::Playing;
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (!rstN || !Enable) begin
			state <= Paused;
			dirPending <= 1'b0;
			dirLeft <= 1'b0;
			position <= 2'd0;
			jumpers <= jumperVecT'(1); // One jumper waiting on the building
			randHold <= '0;
			Score <= '0;
			Lives <= '0;
			Quit <= 1'b0;
		end else begin
			state <= nextState;
			dirPending <= nextDirPending;
			dirLeft <= nextDirLeft;
			position <= nextPos;
			jumpers <= nextJumpers;
			randHold <= nextRand;
			Score <= nextScore;
			Lives <= nextLives;
			Quit <= nextQuit;
		end
	end

	assert property (@(posedge Clock) disable iff (!rstN || !Enable)
		position != 2'd3)
		else $error("gameControl: trampoline off the screen");

	assert property (@(posedge Clock) disable iff (!rstN || !Enable)
		$past(rstN && Enable) |-> Lives >= $past(Lives))
		else $error("gameControl: lives used went down");

endmodule

`default_nettype wire

// ==== beatTimer.sv ====
`default_nettype none

module beatTimer
	import fireGamePkg::*;
#(
	parameter int TicksPerFrame = DefaultTicksPerFrame
) (
	input wire Clock,
	input wire rstN,
	input wire Enable,
	input wire Playing,
	output logic framePulse,
	output logic beatPulse
);

	localparam int FrameW = (FramesPerBeat > 1) ? $clog2(FramesPerBeat) : 1;

	tickT tickCount;
	logic [FrameW-1:0] frameCount;

	// Last tick of a frame, only counted while the game runs
	assign framePulse = Playing && (tickCount == tickT'(TicksPerFrame - 1));
	assign beatPulse = framePulse && (frameCount == FrameW'(FramesPerBeat - 1));

	always_ff @(posedge Clock) begin
		if (!rstN || !Enable) begin
			tickCount <= '0;
			frameCount <= '0;
		end else if (framePulse) begin
			tickCount <= '0;
			if (beatPulse) begin
				frameCount <= '0;
			end else begin
				frameCount <= frameCount + 1'b1;
			end
		end else if (Playing) begin
			tickCount <= tickCount + 1'b1;
		end
	end

	assert property (@(posedge Clock) disable iff (!rstN || !Enable)
		beatPulse |=> tickCount == '0 && frameCount == '0)
		else $error("beatTimer: counts not restarted after a beat");

endmodule

`default_nettype wire

// ==== fireScreenPkg.sv ====
`default_nettype none

package fireScreenPkg;

	import fireGamePkg::*;

	typedef logic [8:0] xCoordT;
	typedef logic [7:0] yCoordT;
	typedef logic [13:0] pixIndexT;

	typedef enum logic [1:0] {
		Blank,
		Spawn,
		Falling,
		Trampoline
	} pixSourceT;

	localparam int JumperSize = 25;
	localparam int FrameStride = JumperSize * JumperSize; // One sprite frame

	// Top-left corner of each jumper slot along the bounce path
	localparam xCoordT SlotX [NumSlots] = '{
		9'd16, 9'd34, 9'd42, 9'd48, 9'd53, 9'd58,
		9'd64, 9'd71, 9'd90, 9'd108, 9'd116, 9'd121,
		9'd126, 9'd133, 9'd142, 9'd163, 9'd184, 9'd193,
		9'd200, 9'd209, 9'd233, 9'd257
	};

	localparam yCoordT SlotY [NumSlots] = '{
		8'd37, 8'd72, 8'd106, 8'd141, 8'd175, 8'd141,
		8'd106, 8'd72, 8'd37, 8'd72, 8'd106, 8'd141,
		8'd175, 8'd141, 8'd106, 8'd72, 8'd106, 8'd141,
		8'd175, 8'd141, 8'd106, 8'd141
	};

	// Slots 4, 12 and 18 sit in the trampoline band
	localparam yCoordT TrampY0 = 8'd180;
	localparam int TrampHeight = 36;
	localparam int TrampWidth = 79;

	localparam xCoordT TrampX [3] = '{
		9'd26,
		9'd99,
		9'd173
	};

endpackage

`default_nettype wire

// ==== fireGamePkg.sv ====
`default_nettype none

package fireGamePkg;

	typedef logic [22:0] tickT;

	localparam int DefaultTicksPerFrame = 5_000_000;
	localparam int FramesPerBeat = 4;

	typedef logic [1:0] posT; // 0 left, 1 centre, 2 right

	localparam int NumSlots = 22;

	// Bit 0 is the spawn slot on the building, bit 21 the ambulance
	typedef logic [NumSlots-1:0] jumperVecT;

	typedef logic [1:0] livesT; // Lives used, not left
	typedef logic [9:0] scoreT;
	typedef logic [15:0] randT;

	typedef enum logic {
		Paused,
		Playing
	} playStateT;

	localparam int DeathSlotLeft = 4;
	localparam int DeathSlotCentre = 12;
	localparam int DeathSlotRight = 18;

	// A jumper arriving here frees slot 11, so the building sends the next one
	localparam int RespawnSlot = 12;

endpackage

`default_nettype wire
